/* verilog/mpx_config.svh */
//----------------------------------------
// Build options for the decode stage
// MPX_SUPPORT_MULDIV is 1 bit
// MPX_SUPPORTED_COP holds one enable bit per coprocessor
//----------------------------------------
`ifndef MPX_CONFIG_SVH
`define MPX_CONFIG_SVH

// Multiply, divide and HI/LO moves
`define MPX_SUPPORT_MULDIV 1'b1

// Bit n enables coprocessor n, default is COP0 and COP2
`define MPX_SUPPORTED_COP 4'd5

`endif

/* verilog/mpx_isa_pkg.sv */
//----------------------------------------
// MIPS-I instruction encoding
// Only the opcodes that decode looks at are listed
//----------------------------------------
package mpx_isa_pkg;

    localparam int OPCODE_W = 6;
    localparam int REG_W    = 5;
    localparam int SHAMT_W  = 5;
    localparam int FUNC_W   = 6;
    localparam int IMM_W    = 16;

    typedef logic [OPCODE_W-1:0] mpx_opcode_t;
    typedef logic [FUNC_W-1:0]   mpx_func_t;
    typedef logic [REG_W-1:0]    mpx_reg_t;

    // One fetched word, seen as R-type or as I-type
    typedef union packed {
        struct packed {
            mpx_opcode_t          opcode;
            mpx_reg_t             rs;
            mpx_reg_t             rt;
            mpx_reg_t             rd;
            logic [SHAMT_W-1:0]   shamt;
            mpx_func_t            func;
        } r;
        struct packed {
            mpx_opcode_t          opcode;
            mpx_reg_t             rs;
            mpx_reg_t             rt;
            logic [IMM_W-1:0]     imm;
        } i;
    } mpx_instr_t;

    //----------------------------------------
    // Primary opcodes
    //----------------------------------------
    localparam mpx_opcode_t INSTR_R_SPECIAL = 6'h00;
    localparam mpx_opcode_t INSTR_I_BRCOND  = 6'h01;
    localparam mpx_opcode_t INSTR_J_J       = 6'h02;
    localparam mpx_opcode_t INSTR_J_JAL     = 6'h03;
    localparam mpx_opcode_t INSTR_J_BEQ     = 6'h04;
    localparam mpx_opcode_t INSTR_J_BNE     = 6'h05;
    localparam mpx_opcode_t INSTR_J_BLEZ    = 6'h06;
    localparam mpx_opcode_t INSTR_J_BGTZ    = 6'h07;
    localparam mpx_opcode_t INSTR_I_ADDI    = 6'h08;
    localparam mpx_opcode_t INSTR_I_ADDIU   = 6'h09;
    localparam mpx_opcode_t INSTR_I_SLTI    = 6'h0a;
    localparam mpx_opcode_t INSTR_I_SLTIU   = 6'h0b;
    localparam mpx_opcode_t INSTR_I_ANDI    = 6'h0c;
    localparam mpx_opcode_t INSTR_I_ORI     = 6'h0d;
    localparam mpx_opcode_t INSTR_I_XORI    = 6'h0e;
    localparam mpx_opcode_t INSTR_I_LUI     = 6'h0f;
    localparam mpx_opcode_t INSTR_COP0      = 6'h10;
    localparam mpx_opcode_t INSTR_COP1      = 6'h11;
    localparam mpx_opcode_t INSTR_COP2      = 6'h12;
    localparam mpx_opcode_t INSTR_COP3      = 6'h13;
    localparam mpx_opcode_t INSTR_I_LB      = 6'h20;
    localparam mpx_opcode_t INSTR_I_LH      = 6'h21;
    localparam mpx_opcode_t INSTR_I_LWL     = 6'h22;
    localparam mpx_opcode_t INSTR_I_LW      = 6'h23;
    localparam mpx_opcode_t INSTR_I_LBU     = 6'h24;
    localparam mpx_opcode_t INSTR_I_LHU     = 6'h25;
    localparam mpx_opcode_t INSTR_I_LWR     = 6'h26;
    localparam mpx_opcode_t INSTR_I_SB      = 6'h28;
    localparam mpx_opcode_t INSTR_I_SH      = 6'h29;
    localparam mpx_opcode_t INSTR_I_SWL     = 6'h2a;
    localparam mpx_opcode_t INSTR_I_SW      = 6'h2b;
    localparam mpx_opcode_t INSTR_I_SWR     = 6'h2e;
    // Low two bits select the coprocessor
    localparam mpx_opcode_t INSTR_I_LWC0    = 6'h30;
    localparam mpx_opcode_t INSTR_I_SWC0    = 6'h38;

    //----------------------------------------
    // SPECIAL function codes
    //----------------------------------------
    localparam mpx_func_t INSTR_R_SLL     = 6'h00;
    localparam mpx_func_t INSTR_R_SRL     = 6'h02;
    localparam mpx_func_t INSTR_R_SRA     = 6'h03;
    localparam mpx_func_t INSTR_R_SLLV    = 6'h04;
    localparam mpx_func_t INSTR_R_SRLV    = 6'h06;
    localparam mpx_func_t INSTR_R_SRAV    = 6'h07;
    localparam mpx_func_t INSTR_R_JR      = 6'h08;
    localparam mpx_func_t INSTR_R_JALR    = 6'h09;
    localparam mpx_func_t INSTR_R_SYSCALL = 6'h0c;
    localparam mpx_func_t INSTR_R_BREAK   = 6'h0d;
    localparam mpx_func_t INSTR_R_MFHI    = 6'h10;
    localparam mpx_func_t INSTR_R_MTHI    = 6'h11;
    localparam mpx_func_t INSTR_R_MFLO    = 6'h12;
    localparam mpx_func_t INSTR_R_MTLO    = 6'h13;
    localparam mpx_func_t INSTR_R_MULT    = 6'h18;
    localparam mpx_func_t INSTR_R_MULTU   = 6'h19;
    localparam mpx_func_t INSTR_R_DIV     = 6'h1a;
    localparam mpx_func_t INSTR_R_DIVU    = 6'h1b;
    localparam mpx_func_t INSTR_R_ADD     = 6'h20;
    localparam mpx_func_t INSTR_R_ADDU    = 6'h21;
    localparam mpx_func_t INSTR_R_SUB     = 6'h22;
    localparam mpx_func_t INSTR_R_SUBU    = 6'h23;
    localparam mpx_func_t INSTR_R_AND     = 6'h24;
    localparam mpx_func_t INSTR_R_OR      = 6'h25;
    localparam mpx_func_t INSTR_R_XOR     = 6'h26;
    localparam mpx_func_t INSTR_R_NOR     = 6'h27;
    localparam mpx_func_t INSTR_R_SLT     = 6'h2a;
    localparam mpx_func_t INSTR_R_SLTU    = 6'h2b;

    // BLTZAL and BGEZAL write the link register
    localparam mpx_reg_t INSTR_I_BRCOND_RA_MASK = 5'h1e;
    localparam mpx_reg_t INSTR_I_BRCOND_RA_WR   = 5'h10;

endpackage

/* verilog/mpx_cop_pkg.sv */
//----------------------------------------
// Coprocessor side of the encoding
// Needs mpx_isa_pkg compiled first
//----------------------------------------
package mpx_cop_pkg;

    localparam int COP_NUM = 4;

    typedef logic [1:0]         mpx_cop_idx_t;
    typedef logic [COP_NUM-1:0] mpx_cop_mask_t;

    // rs field of a COPn word
    typedef enum logic [4:0] {
        COP_MFC = 5'd0,
        COP_CFC = 5'd2,
        COP_MTC = 5'd4,
        COP_CTC = 5'd6
    } mpx_cop_move_t;

    // Return from exception, COP0 with bit 25 set
    localparam mpx_isa_pkg::mpx_func_t COP_FUNC_RFE = 6'h10;

endpackage

/* verilog/mpx_class_decode.sv */
//----------------------------------------
// General instruction classes
// Purely combinational
// Clock and reset only time the checks
// Coprocessor conditions come in from mpx_cop_decode
//----------------------------------------
`timescale 1ns/100ps
`include "mpx_config.svh"

module mpx_class_decode (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  mpx_isa_pkg::mpx_instr_t instr_i,
    input  logic                    cop_reads_gpr_i,
    input  logic                    cop_lsu_i,
    output logic                    exec_o,
    output logic                    lsu_o,
    output logic                    branch_o,
    output logic                    mul_o,
    output logic                    div_o,
    output logic                    rd_valid_o,
    output logic                    rt_is_rd_o,
    output logic                    lr_is_rd_o
);
    import mpx_isa_pkg::*;

    localparam logic MULDIV_EN = `MPX_SUPPORT_MULDIV;

    mpx_opcode_t opcode_w;
    mpx_func_t   func_w;
    logic        imm_alu_w;
    logic        load_w;
    logic        store_w;
    logic        jump_w;
    logic        cop_op_w;
    logic        spec_alu_w;
    logic        spec_jump_w;
    logic        mult_w;
    logic        divide_w;
    logic        jalr_w;
    logic        brcond_link_w;
    logic        exec_w;
    logic        lr_w;

    assign opcode_w = instr_i.r.opcode;
    assign func_w   = instr_i.r.func;

    //----------------------------------------
    // Primary opcode
    //----------------------------------------
    always_comb begin
        imm_alu_w = 1'b0;
        load_w    = 1'b0;
        store_w   = 1'b0;
        jump_w    = 1'b0;
        cop_op_w  = 1'b0;
        case (opcode_w)
            INSTR_I_ADDI, INSTR_I_ADDIU, INSTR_I_SLTI, INSTR_I_SLTIU,
            INSTR_I_ANDI, INSTR_I_ORI, INSTR_I_XORI, INSTR_I_LUI:
                imm_alu_w = 1'b1;
            INSTR_I_LB, INSTR_I_LH, INSTR_I_LW, INSTR_I_LBU,
            INSTR_I_LHU, INSTR_I_LWL, INSTR_I_LWR:
                load_w = 1'b1;
            INSTR_I_SB, INSTR_I_SH, INSTR_I_SW, INSTR_I_SWL, INSTR_I_SWR:
                store_w = 1'b1;
            INSTR_J_J, INSTR_J_JAL, INSTR_J_BEQ, INSTR_J_BNE,
            INSTR_J_BLEZ, INSTR_J_BGTZ, INSTR_I_BRCOND:
                jump_w = 1'b1;
            INSTR_COP0, INSTR_COP1, INSTR_COP2, INSTR_COP3:
                cop_op_w = 1'b1;
            default: ;
        endcase
    end

    //----------------------------------------
    // SPECIAL function field
    //----------------------------------------
    always_comb begin
        spec_alu_w  = 1'b0;
        spec_jump_w = 1'b0;
        mult_w      = 1'b0;
        divide_w    = 1'b0;
        if (opcode_w == INSTR_R_SPECIAL) begin
            case (func_w)
                INSTR_R_SLL, INSTR_R_SRL, INSTR_R_SRA, INSTR_R_SLLV,
                INSTR_R_SRLV, INSTR_R_SRAV, INSTR_R_ADD, INSTR_R_ADDU,
                INSTR_R_SUB, INSTR_R_SUBU, INSTR_R_AND, INSTR_R_OR,
                INSTR_R_XOR, INSTR_R_NOR, INSTR_R_SLT, INSTR_R_SLTU:
                    spec_alu_w = 1'b1;
                INSTR_R_JR, INSTR_R_JALR:
                    spec_jump_w = 1'b1;
                INSTR_R_MULT, INSTR_R_MULTU:
                    mult_w = 1'b1;
                INSTR_R_DIV, INSTR_R_DIVU:
                    divide_w = 1'b1;
                default: ;
            endcase
        end
    end

    assign jalr_w = (opcode_w == INSTR_R_SPECIAL) && (func_w == INSTR_R_JALR);

    // Link forms of BRCOND are picked out of rt
    assign brcond_link_w = (opcode_w == INSTR_I_BRCOND) &&
        ((instr_i.i.rt & INSTR_I_BRCOND_RA_MASK) == INSTR_I_BRCOND_RA_WR);

    assign exec_w = imm_alu_w | spec_alu_w;
    assign lr_w   = (opcode_w == INSTR_J_JAL) | brcond_link_w;

    assign exec_o     = exec_w;
    assign lsu_o      = load_w | store_w | cop_lsu_i;
    assign branch_o   = jump_w | spec_jump_w;
    assign mul_o      = mult_w & MULDIV_EN;
    assign div_o      = divide_w & MULDIV_EN;
    assign lr_is_rd_o = lr_w;
    assign rt_is_rd_o = imm_alu_w | load_w | cop_op_w;
    assign rd_valid_o = exec_w | load_w | lr_w | jalr_w | cop_reads_gpr_i;

    //----------------------------------------
    // Checks
    //----------------------------------------
    // lsu also carries LWC/SWC from the coprocessor decoder
    a_exec_lsu_excl: assert property (@(posedge clk_i) disable iff (reset_i)
        !(exec_o && lsu_o))
        else $error("exec and lsu both set");

endmodule

/* verilog/mpx_cop_decode.sv */
//----------------------------------------
// Coprocessor and special register decode
// HI/LO moves, traps and fetch faults are reported on COP0
// Disabled coprocessors decode as nothing
//----------------------------------------
`timescale 1ns/100ps
`include "mpx_config.svh"

module mpx_cop_decode (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  mpx_isa_pkg::mpx_instr_t   instr_i,
    input  logic                      fault_fetch_i,
    output mpx_cop_pkg::mpx_cop_mask_t cop_o,
    output mpx_cop_pkg::mpx_cop_mask_t cop_wr_o,
    output logic                      cop_reads_gpr_o,
    output logic                      cop_lsu_o
);
    import mpx_isa_pkg::*;
    import mpx_cop_pkg::*;

    localparam mpx_cop_mask_t COP_EN    = `MPX_SUPPORTED_COP;
    localparam logic          MULDIV_EN = `MPX_SUPPORT_MULDIV;

    mpx_opcode_t   opcode_w;
    mpx_func_t     func_w;
    mpx_reg_t      rs_w;
    logic          special_w;
    logic          mfhi_w;
    logic          mthi_w;
    logic          mflo_w;
    logic          mtlo_w;
    logic          trap_w;
    logic          rfe_w;
    logic          cop0_use_w;
    mpx_cop_mask_t hit_w;
    mpx_cop_mask_t op_w;
    mpx_cop_mask_t mf_w;
    mpx_cop_mask_t mt_w;
    mpx_cop_mask_t lwc_w;
    mpx_cop_mask_t swc_w;

    assign opcode_w  = instr_i.r.opcode;
    assign func_w    = instr_i.r.func;
    assign rs_w      = instr_i.r.rs;
    assign special_w = (opcode_w == INSTR_R_SPECIAL);

    //----------------------------------------
    // HI/LO moves and traps
    //----------------------------------------
    assign mfhi_w = special_w && (func_w == INSTR_R_MFHI) && MULDIV_EN;
    assign mthi_w = special_w && (func_w == INSTR_R_MTHI) && MULDIV_EN;
    assign mflo_w = special_w && (func_w == INSTR_R_MFLO) && MULDIV_EN;
    assign mtlo_w = special_w && (func_w == INSTR_R_MTLO) && MULDIV_EN;

    assign trap_w = special_w &&
        ((func_w == INSTR_R_SYSCALL) || (func_w == INSTR_R_BREAK));

    //----------------------------------------
    // Per coprocessor
    //----------------------------------------
    for (genvar n = 0; n < COP_NUM; n++) begin : g_cop
        localparam mpx_cop_idx_t IDX = mpx_cop_idx_t'(n);

        assign hit_w[n] = (opcode_w == {INSTR_COP0[5:2], IDX});
        assign op_w[n]  = hit_w[n] && COP_EN[n];
        assign mf_w[n]  = op_w[n] && ((rs_w == COP_MFC) || (rs_w == COP_CFC));
        assign mt_w[n]  = op_w[n] && ((rs_w == COP_MTC) || (rs_w == COP_CTC));
        assign lwc_w[n] = (opcode_w == {INSTR_I_LWC0[5:2], IDX}) && COP_EN[n];
        assign swc_w[n] = (opcode_w == {INSTR_I_SWC0[5:2], IDX}) && COP_EN[n];
    end

    // Bit 25 is the top bit of rs
    assign rfe_w = op_w[0] && rs_w[REG_W-1] && (func_w == COP_FUNC_RFE);

    // Any COP0 opcode counts, enabled or not
    assign cop0_use_w = trap_w | hit_w[0] | fault_fetch_i |
                        mfhi_w | mflo_w | mthi_w | mtlo_w;

    assign cop_o    = op_w | lwc_w | swc_w | {3'b000, cop0_use_w};
    assign cop_wr_o = mt_w | lwc_w | {3'b000, mthi_w | mtlo_w | rfe_w};

    assign cop_reads_gpr_o = mfhi_w | mflo_w | (|mf_w);
    assign cop_lsu_o       = |(lwc_w | swc_w);

    // A write always comes with the use flag of the same coprocessor
    a_wr_implies_use: assert property (@(posedge clk_i) disable iff (reset_i)
        (cop_wr_o & ~cop_o) == '0)
        else $error("cop_wr %b without cop %b", cop_wr_o, cop_o);

endmodule

/* verilog/mpx_decode.sv */
//----------------------------------------
// Decode stage, purely combinational
// Flags depend on the word and fault flag only, not on valid
// Clock and reset only time the assertions
//----------------------------------------
`timescale 1ns/100ps

module mpx_decode (
    input  logic                       clk_i,
    input  logic                       reset_i,

    // Fetch side
    input  logic                       fetch_in_valid_i,
    input  mpx_isa_pkg::mpx_instr_t    fetch_in_instr_i,
    input  logic [31:0]                fetch_in_pc_i,
    input  logic                       fetch_in_delay_slot_i,
    input  logic                       fetch_in_fault_fetch_i,
    output logic                       fetch_in_accept_o,

    // Next stage
    input  logic                       fetch_out_accept_i,
    output logic                       fetch_out_valid_o,
    output mpx_isa_pkg::mpx_instr_t    fetch_out_instr_o,
    output logic [31:0]                fetch_out_pc_o,
    output logic                       fetch_out_delay_slot_o,
    output logic                       fetch_out_fault_fetch_o,
    output logic                       fetch_out_instr_exec_o,
    output logic                       fetch_out_instr_lsu_o,
    output logic                       fetch_out_instr_branch_o,
    output logic                       fetch_out_instr_mul_o,
    output logic                       fetch_out_instr_div_o,
    output logic                       fetch_out_instr_rd_valid_o,
    output logic                       fetch_out_instr_rt_is_rd_o,
    output logic                       fetch_out_instr_lr_is_rd_o,
    output mpx_cop_pkg::mpx_cop_mask_t fetch_out_instr_cop_o,
    output mpx_cop_pkg::mpx_cop_mask_t fetch_out_instr_cop_wr_o
);

    logic cop_reads_gpr_w;
    logic cop_lsu_w;

    // No buffering, accept goes straight back to fetch
    assign fetch_in_accept_o       = fetch_out_accept_i;
    assign fetch_out_valid_o       = fetch_in_valid_i;
    assign fetch_out_instr_o       = fetch_in_instr_i;
    assign fetch_out_pc_o          = fetch_in_pc_i;
    assign fetch_out_delay_slot_o  = fetch_in_delay_slot_i;
    assign fetch_out_fault_fetch_o = fetch_in_fault_fetch_i;

    mpx_class_decode u_class (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .instr_i         (fetch_in_instr_i),
        .cop_reads_gpr_i (cop_reads_gpr_w),
        .cop_lsu_i       (cop_lsu_w),
        .exec_o          (fetch_out_instr_exec_o),
        .lsu_o           (fetch_out_instr_lsu_o),
        .branch_o        (fetch_out_instr_branch_o),
        .mul_o           (fetch_out_instr_mul_o),
        .div_o           (fetch_out_instr_div_o),
        .rd_valid_o      (fetch_out_instr_rd_valid_o),
        .rt_is_rd_o      (fetch_out_instr_rt_is_rd_o),
        .lr_is_rd_o      (fetch_out_instr_lr_is_rd_o)
    );

    mpx_cop_decode u_cop (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .instr_i         (fetch_in_instr_i),
        .fault_fetch_i   (fetch_in_fault_fetch_i),
        .cop_o           (fetch_out_instr_cop_o),
        .cop_wr_o        (fetch_out_instr_cop_wr_o),
        .cop_reads_gpr_o (cop_reads_gpr_w),
        .cop_lsu_o       (cop_lsu_w)
    );

endmodule

/* sim/tb_mpx_decode.sv */
//----------------------------------------
// Testbench for the decode stage
// Expected flags follow mpx_config.svh
// Inputs change 2 ns after the rising edge, outputs are checked at the falling edge
//----------------------------------------
`timescale 1ns/100ps
`include "mpx_config.svh"

module tb_mpx_decode;
    import mpx_isa_pkg::*;
    import mpx_cop_pkg::*;

    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 4;

    // Cycles per test
    localparam int T_ALU       = 200;
    localparam int T_LSU       = 80;
    localparam int T_BRANCH    = 48;
    localparam int T_MULDIV    = 40;
    localparam int T_COP       = 48;
    localparam int T_HANDSHAKE = 100;
    localparam int TEST_CYCLES = T_ALU + T_LSU + T_BRANCH + T_MULDIV + T_COP + T_HANDSHAKE;
    localparam int CYCLE_LIMIT = TEST_CYCLES * 3 / 2;

    localparam logic          MULDIV = `MPX_SUPPORT_MULDIV;
    localparam mpx_cop_mask_t COP_EN = `MPX_SUPPORTED_COP;

    localparam mpx_func_t ALU_FUNCS [16] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07,
        6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
    localparam mpx_opcode_t LSU_OPS [20] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25,
        6'h26, 6'h28, 6'h29, 6'h2a, 6'h2b, 6'h2e, 6'h30, 6'h31, 6'h32, 6'h33,
        6'h38, 6'h39, 6'h3a, 6'h3b};
    localparam mpx_func_t MULDIV_FUNCS [10] = '{6'h18, 6'h19, 6'h1a, 6'h1b,
        6'h10, 6'h11, 6'h12, 6'h13, 6'h0c, 6'h0d};
    // MFC, CFC, MTC, CTC, then rs with bit 25 set
    localparam mpx_reg_t COP_RS [6] = '{5'h00, 5'h02, 5'h04, 5'h06, 5'h10, 5'h18};

    logic          clk_i;
    logic          reset_i;
    logic          fetch_in_valid_i;
    mpx_instr_t    fetch_in_instr_i;
    logic [31:0]   fetch_in_pc_i;
    logic          fetch_in_delay_slot_i;
    logic          fetch_in_fault_fetch_i;
    logic          fetch_in_accept_o;
    logic          fetch_out_accept_i;
    logic          fetch_out_valid_o;
    mpx_instr_t    fetch_out_instr_o;
    logic [31:0]   fetch_out_pc_o;
    logic          fetch_out_delay_slot_o;
    logic          fetch_out_fault_fetch_o;
    logic          fetch_out_instr_exec_o;
    logic          fetch_out_instr_lsu_o;
    logic          fetch_out_instr_branch_o;
    logic          fetch_out_instr_mul_o;
    logic          fetch_out_instr_div_o;
    logic          fetch_out_instr_rd_valid_o;
    logic          fetch_out_instr_rt_is_rd_o;
    logic          fetch_out_instr_lr_is_rd_o;
    mpx_cop_mask_t fetch_out_instr_cop_o;
    mpx_cop_mask_t fetch_out_instr_cop_wr_o;

    logic          exp_exec;
    logic          exp_lsu;
    logic          exp_branch;
    logic          exp_mul;
    logic          exp_div;
    logic          exp_rd_valid;
    logic          exp_rt_is_rd;
    logic          exp_lr_is_rd;
    mpx_cop_mask_t exp_cop;
    mpx_cop_mask_t exp_cop_wr;

    logic        check_en;
    logic [31:0] next_pc;
    int          check_cnt;
    int          err_cnt;
    int          checks_before;
    int          errs_before;
    int          test_num;
    int          cycle_cnt;

    mpx_decode u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    //----------------------------------------
    // Reference decode
    //----------------------------------------
    function automatic void decode_ref(input mpx_instr_t w, input logic fault,
        output logic exec, output logic lsu, output logic branch, output logic mul,
        output logic div, output logic rd_valid, output logic rt_is_rd,
        output logic lr_is_rd, output mpx_cop_mask_t cop, output mpx_cop_mask_t cop_wr);
        logic         special;
        logic         imm_alu;
        logic         load;
        logic         reads_gpr;
        logic [5:0]   op;
        logic [5:0]   fn;
        logic [4:0]   rs;
        mpx_cop_idx_t idx;

        op      = w.r.opcode;
        fn      = w.r.func;
        rs      = w.r.rs;
        special = (op == 6'h00);
        imm_alu = op inside {[6'h08:6'h0f]};
        load    = op inside {[6'h20:6'h26]};
        exec    = imm_alu || (special &&
                  fn inside {[6'h00:6'h07], [6'h20:6'h27], 6'h2a, 6'h2b} &&
                  fn != 6'h01 && fn != 6'h05);
        lsu     = load || (op inside {6'h28, 6'h29, 6'h2a, 6'h2b, 6'h2e});
        branch  = (op inside {[6'h01:6'h07]}) || (special && fn inside {6'h08, 6'h09});
        // BLTZAL and BGEZAL have rt of 1000x
        lr_is_rd  = (op == 6'h03) || (op == 6'h01 && w.i.rt[4:1] == 4'b1000);
        mul       = MULDIV && special && fn inside {6'h18, 6'h19};
        div       = MULDIV && special && fn inside {6'h1a, 6'h1b};
        rt_is_rd  = imm_alu || load || (op inside {[6'h10:6'h13]});
        reads_gpr = MULDIV && special && fn inside {6'h10, 6'h12};
        cop       = '0;
        cop_wr    = '0;
        for (int n = 0; n < 4; n++) begin
            idx = 2'(n);
            if (COP_EN[idx] && op == {4'b0100, idx}) begin
                cop[idx] = 1'b1;
                if (rs == 5'd0 || rs == 5'd2)
                    reads_gpr = 1'b1;
                if (rs == 5'd4 || rs == 5'd6)
                    cop_wr[idx] = 1'b1;
            end
            if (COP_EN[idx] && (op == {4'b1100, idx} || op == {4'b1110, idx})) begin
                cop[idx] = 1'b1;
                lsu      = 1'b1;
                cop_wr[idx] = (op[3] == 1'b0);
            end
        end
        if (op == 6'h10 || fault || (special && fn inside {6'h0c, 6'h0d}))
            cop[0] = 1'b1;
        // MTHI and MTLO have odd function codes
        if (MULDIV && special && fn inside {[6'h10:6'h13]}) begin
            cop[0] = 1'b1;
            cop_wr[0] = cop_wr[0] | fn[0];
        end
        if (COP_EN[0] && op == 6'h10 && rs[4] && fn == 6'h10)
            cop_wr[0] = 1'b1;
        rd_valid = exec || load || lr_is_rd || (special && fn == 6'h09) || reads_gpr;
    endfunction

    //----------------------------------------
    // Compare tasks
    //----------------------------------------
    task automatic flag_check(input string name, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic mask_check(input string name, input mpx_cop_mask_t exp,
        input mpx_cop_mask_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic instr_check(input string name, input mpx_instr_t exp,
        input mpx_instr_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic pc_check(input string name, input logic [31:0] exp,
        input logic [31:0] act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    always @(negedge clk_i) begin
        if (check_en) begin
            decode_ref(fetch_in_instr_i, fetch_in_fault_fetch_i, exp_exec, exp_lsu,
                exp_branch, exp_mul, exp_div, exp_rd_valid, exp_rt_is_rd, exp_lr_is_rd,
                exp_cop, exp_cop_wr);
            flag_check("fetch_in_accept_o", fetch_out_accept_i, fetch_in_accept_o);
            flag_check("fetch_out_valid_o", fetch_in_valid_i, fetch_out_valid_o);
            flag_check("fetch_out_delay_slot_o", fetch_in_delay_slot_i, fetch_out_delay_slot_o);
            flag_check("fetch_out_fault_fetch_o", fetch_in_fault_fetch_i,
                fetch_out_fault_fetch_o);
            instr_check("fetch_out_instr_o", fetch_in_instr_i, fetch_out_instr_o);
            pc_check("fetch_out_pc_o", fetch_in_pc_i, fetch_out_pc_o);
            flag_check("fetch_out_instr_exec_o", exp_exec, fetch_out_instr_exec_o);
            flag_check("fetch_out_instr_lsu_o", exp_lsu, fetch_out_instr_lsu_o);
            flag_check("fetch_out_instr_branch_o", exp_branch, fetch_out_instr_branch_o);
            flag_check("fetch_out_instr_mul_o", exp_mul, fetch_out_instr_mul_o);
            flag_check("fetch_out_instr_div_o", exp_div, fetch_out_instr_div_o);
            flag_check("fetch_out_instr_rd_valid_o", exp_rd_valid, fetch_out_instr_rd_valid_o);
            flag_check("fetch_out_instr_rt_is_rd_o", exp_rt_is_rd, fetch_out_instr_rt_is_rd_o);
            flag_check("fetch_out_instr_lr_is_rd_o", exp_lr_is_rd, fetch_out_instr_lr_is_rd_o);
            mask_check("fetch_out_instr_cop_o", exp_cop, fetch_out_instr_cop_o);
            mask_check("fetch_out_instr_cop_wr_o", exp_cop_wr, fetch_out_instr_cop_wr_o);
        end
    end

    //----------------------------------------
    // Stimulus
    //----------------------------------------
    task automatic drive_cycle(input mpx_instr_t w, input logic fault, input logic valid,
        input logic accept, input logic delay, input logic [31:0] pc);
        @(posedge clk_i);
        #DRIVE_DELAY;
        fetch_in_instr_i       = w;
        fetch_in_fault_fetch_i = fault;
        fetch_in_valid_i       = valid;
        fetch_out_accept_i     = accept;
        fetch_in_delay_slot_i  = delay;
        fetch_in_pc_i          = pc;
    endtask

    task automatic send_word(input mpx_instr_t w);
        drive_cycle(w, 1'b0, 1'b1, 1'b1, 1'b0, next_pc);
        next_pc = next_pc + 32'd4;
    endtask

    // Last word is checked at the falling edge before this returns
    task automatic report_test(input string name);
        @(posedge clk_i);
        test_num++;
        $display("test %0d %s: %0d checks, %0d errors", test_num, name,
            check_cnt - checks_before, err_cnt - errs_before);
        checks_before = check_cnt;
        errs_before   = err_cnt;
    endtask

    function automatic mpx_instr_t random_alu_word();
        mpx_instr_t w;

        w = $urandom;
        if ($urandom_range(1, 0) == 0) begin
            w.i.opcode = {3'b001, 3'($urandom_range(7, 0))};
        end else begin
            w.r.opcode = INSTR_R_SPECIAL;
            w.r.func   = ALU_FUNCS[4'($urandom_range(15, 0))];
        end
        return w;
    endfunction

    initial begin : run_tests
        mpx_instr_t w;

        void'($urandom(48263));
        reset_i                = 1'b1;
        fetch_in_valid_i       = 1'b0;
        fetch_in_instr_i       = '0;
        fetch_in_pc_i          = '0;
        fetch_in_delay_slot_i  = 1'b0;
        fetch_in_fault_fetch_i = 1'b0;
        fetch_out_accept_i     = 1'b0;
        check_en      = 1'b0;
        next_pc       = 32'h0000_1000;
        check_cnt     = 0;
        err_cnt       = 0;
        checks_before = 0;
        errs_before   = 0;
        test_num      = 0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY reset_i = 1'b0;
        check_en = 1'b1;

        repeat (T_ALU) send_word(random_alu_word());
        report_test("immediate and SPECIAL ALU");

        for (int k = 0; k < 20; k++) begin
            repeat (4) begin
                w = $urandom;
                w.i.opcode = LSU_OPS[5'(k)];
                send_word(w);
            end
        end
        report_test("loads, stores, LWC and SWC");

        // J to BGTZ, then every BRCOND rt, then JR and JALR
        for (int k = 0; k < 12; k++) begin
            w = $urandom;
            w.i.opcode = 6'(k / 2 + 2);
            send_word(w);
        end
        for (int k = 0; k < 32; k++) begin
            w = $urandom;
            w.i.opcode = INSTR_I_BRCOND;
            w.i.rt     = 5'(k);
            send_word(w);
        end
        for (int k = 0; k < 4; k++) begin
            w = $urandom;
            w.r.opcode = INSTR_R_SPECIAL;
            w.r.func   = k[0] ? INSTR_R_JALR : INSTR_R_JR;
            send_word(w);
        end
        report_test("branches and links");

        for (int k = 0; k < 10; k++) begin
            repeat (4) begin
                w = $urandom;
                w.r.opcode = INSTR_R_SPECIAL;
                w.r.func   = MULDIV_FUNCS[4'(k)];
                send_word(w);
            end
        end
        report_test("multiply, divide, HI/LO and traps");

        for (int n = 0; n < 4; n++) begin
            for (int r = 0; r < 6; r++) begin
                for (int f = 0; f < 2; f++) begin
                    w = $urandom;
                    w.r.opcode = {4'b0100, 2'(n)};
                    w.r.rs     = COP_RS[3'(r)];
                    if (f == 1)
                        w.r.func = COP_FUNC_RFE;
                    send_word(w);
                end
            end
        end
        report_test("coprocessor moves and RFE");

        repeat (T_HANDSHAKE) begin
            drive_cycle($urandom, ($urandom % 4) == 0, 1'($urandom), 1'($urandom),
                1'($urandom), $urandom & 32'hffff_fffc);
        end
        report_test("handshake and sideband");

        check_en = 1'b0;
        $display("tests %0d, checks %0d, errors %0d", test_num, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* mpx_decode.f */
+incdir+verilog
verilog/mpx_isa_pkg.sv
verilog/mpx_cop_pkg.sv
verilog/mpx_class_decode.sv
verilog/mpx_cop_decode.sv
verilog/mpx_decode.sv
sim/tb_mpx_decode.sv

/* Makefile */
# Verilator flow for the MIPS-I decode stage

TB = tb_mpx_decode

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f mpx_decode.f --top-module mpx_decode

# Pass only if the log holds the pass line
sim:
	verilator --binary --timing --assert -f mpx_decode.f --top-module $(TB) -o $(TB)
	./obj_dir/$(TB) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
